//--- rp_analog_top.f
+incdir+tb
design/rp_bus_pkg.sv
design/rp_sig_pkg.sv
design/sys_bus_decoder.sv
design/adc_frontend.sv
design/hk_regs.sv
design/asg_table.sv
design/p_controller.sv
design/dac_backend.sv
design/rp_analog_top.sv
tb/tb_rp_analog_top.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rp_analog_top -f rp_analog_top.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_rp_analog_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Testbench passed" "$LOG"; then
  exit 0
fi
exit 1

//--- tb/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// lcg, numerical recipes constants
function automatic logic [31:0] lcg_next();
  seed = seed * 32'd1664525 + 32'd1013904223;
  return seed;
endfunction

////////////////////
// one clock step, inputs change just after the edge
task automatic tick();
  logic [31:0] r;
  @(posedge adc_clk);
  #(DRIVE_DLY);
  if (adc_rand)
  begin
    for (int ch = 0; ch < N_CH; ch++)
    begin
      r           = lcg_next();
      adc_dat[ch] = r[31:16];  // upper bits are the better ones
    end
  end
endtask

function automatic sys_addr_t addr_of(input region_t rg, input offs_t of);
  return (sys_addr_t'(rg) << REGION_LSB) | sys_addr_t'(of);
endfunction

////////////////////
// typed compares
task automatic compare_data(input string name, input sys_data_t got, input sys_data_t exp);
  if (got !== exp)
  begin
    n_mismatch++;
    $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
  end
endtask

task automatic compare_flag(input string name, input logic got, input logic exp);
  if (got !== exp)
  begin
    n_mismatch++;
    $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
  end
endtask

task automatic compare_code(input string name, input logic [SMP_W-1:0] got,
                            input logic [SMP_W-1:0] exp);
  if (got !== exp)
  begin
    n_mismatch++;
    $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
  end
endtask

////////////////////
// bus master, one pulse then wait for ack
task automatic bus_access(input logic wr, input sys_addr_t addr, input sys_data_t wdata,
                          output sys_data_t rdata, output logic err);
  int waited;
  waited    = 0;
  sys_addr  = addr;
  sys_wdata = wdata;
  sys_wen   = wr;
  sys_ren   = ~wr;
  tick();
  sys_wen = 1'b0;  // strobe is a single cycle
  sys_ren = 1'b0;
  while (sys_ack !== 1'b1 && waited < ACK_LIMIT)
  begin
    tick();
    waited++;
  end
  if (sys_ack !== 1'b1)
  begin
    n_other++;
    $display("no bus ack within %0d cycles for address %h at %0t ns", ACK_LIMIT, addr, $time);
  end
  rdata = sys_rdata;
  err   = sys_err;
endtask

task automatic bus_write(input sys_addr_t addr, input sys_data_t wdata, input logic exp_err);
  sys_data_t rd;
  logic      err;
  bus_access(1'b1, addr, wdata, rd, err);
  compare_flag("sys_err_o", err, exp_err);
endtask

task automatic bus_read(input sys_addr_t addr, input sys_data_t exp, input logic exp_err);
  sys_data_t rd;
  logic      err;
  bus_access(1'b0, addr, '0, rd, err);
  if (!exp_err)
    compare_data("sys_rdata_o", rd, exp);
  compare_flag("sys_err_o", err, exp_err);
endtask

task automatic set_pid(input int ch, input int sp, input int kp);
  bus_write(addr_of(REG_PID, OFS_SP | offs_t'(ch << 4)), sys_data_t'(sp) & 32'h3fff, 1'b0);
  bus_write(addr_of(REG_PID, OFS_KP | offs_t'(ch << 4)), sys_data_t'(kp) & 32'h3fff, 1'b0);
endtask

// same value in every entry of one table
task automatic fill_table(input int ch, input int val);
  for (int k = 0; k < TBL_DEPTH; k++)
    bus_write(addr_of(REG_ASG, OFS_ASG_TBL | offs_t'((ch << 6) | (k << 2))),
              sys_data_t'(val) & 32'h3fff, 1'b0);
endtask

`endif

//--- tb/tb_rp_analog_top.sv
`timescale 1ns/1ns

module tb_rp_analog_top;
  import rp_bus_pkg::*;
  import rp_sig_pkg::*;

  localparam int CLK_HALF  = 5;
  localparam int DRIVE_DLY = 1;    // inputs change 1 ns after the edge
  localparam int RESET_CYC = 16;
  localparam int ACK_LIMIT = 8;    // cycles to wait for an ack
  localparam int N_PROP    = 200;
  localparam int N_SAT     = 64;
  localparam int N_PLAY    = 48;
  localparam int N_LOOP    = 120;
  localparam int N_IDLE    = 40;   // settling ticks between tests
  localparam int BUS_OPS   = 200;  // upper bound on bus accesses
  localparam int RUN_CYC   = RESET_CYC + N_PROP + N_SAT + N_PLAY + N_LOOP + N_IDLE
                             + BUS_OPS * (ACK_LIMIT + 1);
  localparam int WATCHDOG_NS = RUN_CYC * 2 * CLK_HALF + 1000;

  logic                adc_clk;
  logic                reset;
  adc_raw_t [N_CH-1:0] adc_dat;
  sys_addr_t           sys_addr;
  sys_data_t           sys_wdata;
  logic                sys_wen;
  logic                sys_ren;
  sys_data_t           sys_rdata;
  logic                sys_err;
  logic                sys_ack;
  logic [SMP_W-1:0]    dac_a;
  logic [SMP_W-1:0]    dac_b;
  logic [7:0]          led;

  logic [31:0] seed;
  logic        adc_rand;   // fresh ADC words every cycle
  logic        chk_en;
  int          n_mismatch;
  int          n_other;

  ////////////////////
  // reference model state
  logic [SMP_W-1:0] m_raw [N_CH];  // captured ADC code
  int               m_pid [N_CH];
  int               m_asg [N_CH];
  int               m_ptr [N_CH];
  int               m_sp  [N_CH];
  int               m_kp  [N_CH];
  int               m_tbl [N_CH][TBL_DEPTH];
  logic [N_CH-1:0]    m_ena;
  logic               m_loop;
  logic [7:0]         m_led;
  logic [SMP_W-1:0]   m_dac [N_CH];

  `include "tb_tasks.svh"

  always #CLK_HALF adc_clk = ~adc_clk;

  rp_analog_top u_dut (
    .adc_clk     (adc_clk),
    .reset_i     (reset),
    .adc_dat_i   (adc_dat),
    .sys_addr_i  (sys_addr),
    .sys_wdata_i (sys_wdata),
    .sys_wen_i   (sys_wen),
    .sys_ren_i   (sys_ren),
    .sys_rdata_o (sys_rdata),
    .sys_err_o   (sys_err),
    .sys_ack_o   (sys_ack),
    .dac_a_o     (dac_a),
    .dac_b_o     (dac_b),
    .led_o       (led)
  );

  ////////////////////
  // sample format helpers
  function automatic int sext14(input logic [SMP_W-1:0] v);
    return v[SMP_W-1] ? int'(v) - (1 << SMP_W) : int'(v);
  endfunction

  function automatic int clamp14(input int v);
    if (v > int'(SMP_MAX))
      return int'(SMP_MAX);
    if (v < int'(SMP_MIN))
      return int'(SMP_MIN);
    return v;
  endfunction

  // offset code, msb kept and the rest inverted
  function automatic logic [SMP_W-1:0] code_of(input int v);
    logic [SMP_W-1:0] s;
    s = v[SMP_W-1:0];
    return {s[SMP_W-1], ~s[SMP_W-2:0]};
  endfunction

  ////////////////////
  // one clock of the whole analog path, all updates from old state
  function automatic void step_model();
    int      sum [N_CH];
    int      nxt [N_CH];
    int      smp;
    region_t rg;
    offs_t   of;
    if (reset)
    begin
      for (int ch = 0; ch < N_CH; ch++)
      begin
        m_raw[ch] = 14'h1fff;  // midscale, reads as 0
        m_pid[ch] = 0;
        m_asg[ch] = 0;
        m_ptr[ch] = 0;
        m_sp[ch]  = 0;
        m_kp[ch]  = 0;
        m_dac[ch] = 14'h1fff;
      end
      m_ena  = '0;
      m_loop = 1'b0;
      m_led  = '0;
      return;
    end
    for (int ch = 0; ch < N_CH; ch++)
    begin
      sum[ch] = clamp14(m_asg[ch] + m_pid[ch]);
      // loopback takes this cycle's sum
      smp     = m_loop ? sum[ch] : sext14({m_raw[ch][SMP_W-1], ~m_raw[ch][SMP_W-2:0]});
      nxt[ch] = clamp14(((m_sp[ch] - smp) * m_kp[ch]) >>> PID_SHIFT);
    end
    for (int ch = 0; ch < N_CH; ch++)
    begin
      m_dac[ch] = code_of(sum[ch]);
      if (m_ena[ch])
      begin
        m_asg[ch] = m_tbl[ch][m_ptr[ch]];
        m_ptr[ch] = (m_ptr[ch] + 1) % TBL_DEPTH;  // wraps at 16
      end
      else
      begin
        m_asg[ch] = 0;
        m_ptr[ch] = 0;
      end
      m_pid[ch] = nxt[ch];
      m_raw[ch] = adc_dat[ch][ADC_RAW_W-1 -: SMP_W];  // low 2 bits dropped
    end
    // register writes land at this edge
    rg = sys_addr[REGION_LSB +: $bits(region_t)];
    of = sys_addr[REGION_LSB-1:0];
    if (sys_wen)
    begin
      if (rg == REG_HK && of == OFS_LOOP)
        m_loop = sys_wdata[0];
      if (rg == REG_HK && of == OFS_LED)
        m_led = sys_wdata[7:0];
      if (rg == REG_ASG && of == OFS_ASG_CTL)
        m_ena = sys_wdata[N_CH-1:0];
      if (rg == REG_ASG && of[REGION_LSB-1:7] == 13'h1)  // 0x80..0xff
        m_tbl[of[6]][of[5:2]] = sext14(sys_wdata[SMP_W-1:0]);
      if (rg == REG_PID && (of & ~offs_t'('h10)) == OFS_SP)
        m_sp[of[4]] = sext14(sys_wdata[SMP_W-1:0]);
      if (rg == REG_PID && (of & ~offs_t'('h10)) == OFS_KP)
        m_kp[of[4]] = sext14(sys_wdata[SMP_W-1:0]);
    end
  endfunction

  always @(posedge adc_clk)
  begin
    step_model();
  end

  // outputs settled by the falling edge
  always @(negedge adc_clk)
  begin
    if (chk_en)
    begin
      compare_code("dac_a_o", dac_a, m_dac[0]);
      compare_code("dac_b_o", dac_b, m_dac[1]);
      compare_data("led_o", sys_data_t'(led), sys_data_t'(m_led));
    end
  end

  ////////////////////
  // tests
  task automatic run_round_trip();
    logic [31:0] r;
    sys_addr_t   a;
    bus_write(addr_of(REG_HK, OFS_LED), 32'h0000_01a5, 1'b0);
    bus_read(addr_of(REG_HK, OFS_LED), 32'h0000_00a5, 1'b0);  // 8 bit field
    bus_write(addr_of(REG_HK, OFS_LOOP), 32'h0000_0003, 1'b0);
    bus_read(addr_of(REG_HK, OFS_LOOP), 32'h0000_0001, 1'b0);
    bus_write(addr_of(REG_HK, OFS_LOOP), 32'h0, 1'b0);
    for (int i = 0; i < N_CH * TBL_DEPTH; i++)
    begin
      r = lcg_next();
      a = addr_of(REG_ASG, OFS_ASG_TBL | offs_t'(i << 2));  // bit 6 is the channel
      bus_write(a, r, 1'b0);
      bus_read(a, r & 32'h3fff, 1'b0);
    end
    bus_write(addr_of(REG_ASG, OFS_ASG_CTL), 32'hffff_ffff, 1'b0);
    bus_read(addr_of(REG_ASG, OFS_ASG_CTL), 32'h3, 1'b0);
    repeat (20) tick();  // both tables play
    bus_write(addr_of(REG_ASG, OFS_ASG_CTL), 32'h0, 1'b0);
    for (int ch = 0; ch < N_CH; ch++)
    begin
      r = lcg_next();
      a = addr_of(REG_PID, OFS_SP | offs_t'(ch << 4));
      bus_write(a, r, 1'b0);
      bus_read(a, r & 32'h3fff, 1'b0);
      r = lcg_next();
      a = addr_of(REG_PID, OFS_KP | offs_t'(ch << 4));
      bus_write(a, r, 1'b0);
      bus_read(a, r & 32'h3fff, 1'b0);
    end
  endtask

  task automatic run_unmapped();
    for (int rg = 3; rg < N_REGIONS; rg++)
    begin
      bus_write(addr_of(region_t'(rg), OFS_LOOP), lcg_next(), 1'b1);
      bus_read(addr_of(region_t'(rg), OFS_LED), 32'h0, 1'b1);
    end
  endtask

  task automatic run_prop();
    logic [31:0] r;
    for (int ch = 0; ch < N_CH; ch++)
    begin
      r = lcg_next();
      set_pid(ch, sext14(r[SMP_W-1:0]), int'(r[23:16]) - 128);  // small gain
    end
    repeat (N_PROP) tick();
  endtask

  task automatic run_sat();
    fill_table(0, int'(SMP_MAX));
    fill_table(1, int'(SMP_MIN));
    set_pid(0, int'(SMP_MAX), int'(SMP_MAX));  // error never negative
    set_pid(1, int'(SMP_MIN), int'(SMP_MAX));  // error never positive
    bus_write(addr_of(REG_ASG, OFS_ASG_CTL), 32'h3, 1'b0);
    repeat (N_SAT) tick();
    compare_code("dac_a_o", dac_a, code_of(int'(SMP_MAX)));
    compare_code("dac_b_o", dac_b, code_of(int'(SMP_MIN)));
    bus_write(addr_of(REG_ASG, OFS_ASG_CTL), 32'h0, 1'b0);
  endtask

  task automatic run_play();
    int          vals [N_CH][TBL_DEPTH];
    logic [31:0] r;
    set_pid(0, 0, 0);
    set_pid(1, 0, 0);
    for (int ch = 0; ch < N_CH; ch++)
    begin
      for (int k = 0; k < TBL_DEPTH; k++)
      begin
        r           = lcg_next();
        vals[ch][k] = sext14(r[SMP_W-1:0]);
        bus_write(addr_of(REG_ASG, OFS_ASG_TBL | offs_t'((ch << 6) | (k << 2))),
                  sys_data_t'(vals[ch][k]) & 32'h3fff, 1'b0);
      end
    end
    bus_write(addr_of(REG_ASG, OFS_ASG_CTL), 32'h3, 1'b0);
    // entry 0 reaches the DAC two cycles after the ack
    tick();
    for (int k = 0; k < N_PLAY; k++)
    begin
      tick();
      compare_code("dac_a_o", dac_a, code_of(vals[0][k % TBL_DEPTH]));
      compare_code("dac_b_o", dac_b, code_of(vals[1][k % TBL_DEPTH]));
    end
    bus_write(addr_of(REG_ASG, OFS_ASG_CTL), 32'h0, 1'b0);
  endtask

  task automatic run_loop();
    logic [31:0] r;
    for (int ch = 0; ch < N_CH; ch++)
    begin
      r = lcg_next();
      set_pid(ch, sext14(r[SMP_W-1:0]), int'(r[24:16]) - 256);
    end
    bus_write(addr_of(REG_HK, OFS_LOOP), 32'h1, 1'b0);
    repeat (N_LOOP) tick();  // ADC words ignored here
    bus_write(addr_of(REG_HK, OFS_LOOP), 32'h0, 1'b0);
    repeat (4) tick();
  endtask

  ////////////////////
  initial
  begin
    adc_clk    = 1'b0;
    reset      = 1'b1;
    adc_dat    = '0;
    sys_addr   = '0;
    sys_wdata  = '0;
    sys_wen    = 1'b0;
    sys_ren    = 1'b0;
    seed       = 32'h8167e3b4;
    adc_rand   = 1'b0;
    chk_en     = 1'b0;
    n_mismatch = 0;
    n_other    = 0;
    repeat (RESET_CYC) tick();
    reset    = 1'b0;
    chk_en   = 1'b1;
    adc_rand = 1'b1;
    compare_code("dac_a_o", dac_a, 14'h1fff);  // code for 0
    compare_code("dac_b_o", dac_b, 14'h1fff);
    run_round_trip();
    run_unmapped();
    run_prop();
    run_sat();
    run_play();
    run_loop();
    $display("checks done, %0d mismatches, %0d other errors", n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  // hard stop
  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout, run did not finish within %0d ns", WATCHDOG_NS);
    $display("Testbench failed");
    $finish;
  end

endmodule

//--- design/rp_analog_top.sv
`timescale 1ns/1ns

module rp_analog_top (
  input  logic                                          adc_clk,
  input  logic                                          reset_i,
  input  rp_sig_pkg::adc_raw_t [rp_sig_pkg::N_CH-1:0]   adc_dat_i,
  input  rp_bus_pkg::sys_addr_t                         sys_addr_i,
  input  rp_bus_pkg::sys_data_t                         sys_wdata_i,
  input  logic                                          sys_wen_i,
  input  logic                                          sys_ren_i,
  output rp_bus_pkg::sys_data_t                         sys_rdata_o,
  output logic                                          sys_err_o,
  output logic                                          sys_ack_o,
  output logic [rp_sig_pkg::SMP_W-1:0]                  dac_a_o,
  output logic [rp_sig_pkg::SMP_W-1:0]                  dac_b_o,
  output logic [7:0]                                    led_o
);

  // bus side
  logic                  hk_wen, hk_ren, asg_wen, asg_ren, pid_wen, pid_ren;
  logic                  hk_ack, asg_ack, pid_ack;
  rp_bus_pkg::offs_t     offs;
  rp_bus_pkg::sys_data_t wdata;
  rp_bus_pkg::sys_data_t hk_rdata, asg_rdata, pid_rdata;

  // data path
  rp_sig_pkg::smp_t adc_smp  [rp_sig_pkg::N_CH];
  rp_sig_pkg::smp_t loop_dat [rp_sig_pkg::N_CH];  // saturated sums
  rp_sig_pkg::smp_t asg_a, asg_b, pid_a, pid_b;
  logic             loop;

  ////////////////////
  sys_bus_decoder u_decoder (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .hk_rdata_i  (hk_rdata),
    .asg_rdata_i (asg_rdata),
    .pid_rdata_i (pid_rdata),
    .hk_ack_i    (hk_ack),
    .asg_ack_i   (asg_ack),
    .pid_ack_i   (pid_ack),
    .hk_wen_o    (hk_wen),
    .hk_ren_o    (hk_ren),
    .asg_wen_o   (asg_wen),
    .asg_ren_o   (asg_ren),
    .pid_wen_o   (pid_wen),
    .pid_ren_o   (pid_ren),
    .offs_o      (offs),
    .wdata_o     (wdata),
    .sys_rdata_o (sys_rdata_o),
    .sys_err_o   (sys_err_o),
    .sys_ack_o   (sys_ack_o)
  );

  // one front end per channel
  for (genvar ch = 0; ch < rp_sig_pkg::N_CH; ch++)
  begin : g_adc
    adc_frontend u_adc (
      .adc_clk    (adc_clk),
      .reset_i    (reset_i),
      .adc_dat_i  (adc_dat_i[ch]),
      .loop_i     (loop),
      .loop_dat_i (loop_dat[ch]),
      .smp_o      (adc_smp[ch])
    );
  end

  hk_regs u_hk (
    .adc_clk (adc_clk),
    .reset_i (reset_i),
    .wen_i   (hk_wen),
    .ren_i   (hk_ren),
    .offs_i  (offs),
    .wdata_i (wdata),
    .rdata_o (hk_rdata),
    .ack_o   (hk_ack),
    .loop_o  (loop),
    .led_o   (led_o)
  );

  asg_table u_asg (
    .adc_clk (adc_clk),
    .reset_i (reset_i),
    .wen_i   (asg_wen),
    .ren_i   (asg_ren),
    .offs_i  (offs),
    .wdata_i (wdata),
    .rdata_o (asg_rdata),
    .ack_o   (asg_ack),
    .asg_a_o (asg_a),
    .asg_b_o (asg_b)
  );

  p_controller u_pid (
    .adc_clk (adc_clk),
    .reset_i (reset_i),
    .wen_i   (pid_wen),
    .ren_i   (pid_ren),
    .offs_i  (offs),
    .wdata_i (wdata),
    .dat_a_i (adc_smp[0]),
    .dat_b_i (adc_smp[1]),
    .rdata_o (pid_rdata),
    .ack_o   (pid_ack),
    .pid_a_o (pid_a),
    .pid_b_o (pid_b)
  );

  dac_backend u_dac (
    .adc_clk (adc_clk),
    .reset_i (reset_i),
    .asg_a_i (asg_a),
    .asg_b_i (asg_b),
    .pid_a_i (pid_a),
    .pid_b_i (pid_b),
    .sum_a_o (loop_dat[0]),
    .sum_b_o (loop_dat[1]),
    .dac_a_o (dac_a_o),
    .dac_b_o (dac_b_o)
  );

endmodule

//--- design/dac_backend.sv
`timescale 1ns/1ns

module dac_backend (
  input  logic                         adc_clk,
  input  logic                         reset_i,
  input  rp_sig_pkg::smp_t             asg_a_i,
  input  rp_sig_pkg::smp_t             asg_b_i,
  input  rp_sig_pkg::smp_t             pid_a_i,
  input  rp_sig_pkg::smp_t             pid_b_i,
  output rp_sig_pkg::smp_t             sum_a_o,  // to loopback, unregistered
  output rp_sig_pkg::smp_t             sum_b_o,
  output logic [rp_sig_pkg::SMP_W-1:0] dac_a_o,  // offset code
  output logic [rp_sig_pkg::SMP_W-1:0] dac_b_o
);
  import rp_sig_pkg::*;

  logic signed [SMP_W:0] sum_a;  // one guard bit
  logic signed [SMP_W:0] sum_b;

  // two top bits differ means overflow
  function automatic smp_t clamp(input logic signed [SMP_W:0] s);
    if (s[SMP_W] != s[SMP_W-1])
      return s[SMP_W] ? SMP_MIN : SMP_MAX;
    return s[SMP_W-1:0];
  endfunction

  assign sum_a   = asg_a_i + pid_a_i;
  assign sum_b   = asg_b_i + pid_b_i;
  assign sum_a_o = clamp(sum_a);
  assign sum_b_o = clamp(sum_b);

  ////////////////////
  // output register, back to negative slope offset code
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      dac_a_o <= {1'b0, {(SMP_W-1){1'b1}}};  // 14'h1fff is zero
      dac_b_o <= {1'b0, {(SMP_W-1){1'b1}}};
    end
    else
    begin
      dac_a_o <= {sum_a_o[SMP_W-1], ~sum_a_o[SMP_W-2:0]};
      dac_b_o <= {sum_b_o[SMP_W-1], ~sum_b_o[SMP_W-2:0]};
    end
  end

endmodule

//--- design/p_controller.sv
`timescale 1ns/1ns

module p_controller (
  input  logic                  adc_clk,
  input  logic                  reset_i,
  input  logic                  wen_i,
  input  logic                  ren_i,
  input  rp_bus_pkg::offs_t     offs_i,
  input  rp_bus_pkg::sys_data_t wdata_i,
  input  rp_sig_pkg::smp_t      dat_a_i,
  input  rp_sig_pkg::smp_t      dat_b_i,
  output rp_bus_pkg::sys_data_t rdata_o,
  output logic                  ack_o,
  output rp_sig_pkg::smp_t      pid_a_o,
  output rp_sig_pkg::smp_t      pid_b_o
);
  import rp_bus_pkg::*;
  import rp_sig_pkg::*;

  smp_t                    sp   [N_CH];  // setpoints
  kp_t                     kp   [N_CH];  // gains
  smp_t                    dat  [N_CH];
  logic signed [SMP_W:0]   err  [N_CH];  // 15 bit, no overflow
  logic signed [2*SMP_W:0] prod [N_CH];
  logic signed [2*SMP_W:0] shf  [N_CH];
  smp_t                    sat  [N_CH];
  logic                    ch_sel;
  offs_t                   reg_ofs;      // offset with channel bit cleared

  assign dat[0] = dat_a_i;
  assign dat[1] = dat_b_i;
  assign ch_sel = offs_i[4];

  always_comb
  begin
    reg_ofs    = offs_i;
    reg_ofs[4] = 1'b0;
  end

  ////////////////////
  // registers, channel b at +0x10
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      for (int ch = 0; ch < N_CH; ch++)
      begin
        sp[ch] <= '0;
        kp[ch] <= '0;
      end
      ack_o <= 1'b0;
    end
    else
    begin
      ack_o <= wen_i | ren_i;
      if (wen_i && reg_ofs == OFS_SP)
        sp[ch_sel] <= smp_t'(wdata_i[SMP_W-1:0]);
      if (wen_i && reg_ofs == OFS_KP)
        kp[ch_sel] <= kp_t'(wdata_i[$bits(kp_t)-1:0]);
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (ren_i)
    begin
      if (reg_ofs == OFS_SP)
        rdata_o <= {{(SYS_DW-SMP_W){1'b0}}, sp[ch_sel]};
      else if (reg_ofs == OFS_KP)
        rdata_o <= {{(SYS_DW-$bits(kp_t)){1'b0}}, kp[ch_sel]};
      else
        rdata_o <= '0;
    end
  end

  ////////////////////
  // proportional path: kp * (sp - x) >>> 8, then clamp
  always_comb
  begin
    for (int ch = 0; ch < N_CH; ch++)
    begin
      err[ch]  = sp[ch] - dat[ch];
      prod[ch] = err[ch] * kp[ch];
      shf[ch]  = prod[ch] >>> PID_SHIFT;
      if (shf[ch] > SMP_MAX)
        sat[ch] = SMP_MAX;
      else if (shf[ch] < SMP_MIN)
        sat[ch] = SMP_MIN;
      else
        sat[ch] = shf[ch][SMP_W-1:0];
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      pid_a_o <= '0;
      pid_b_o <= '0;
    end
    else
    begin
      pid_a_o <= sat[0];  // one cycle from sample
      pid_b_o <= sat[1];
    end
  end

  // clamping never wraps, output keeps the sign of the product
  a_sign_a: assert property (@(posedge adc_clk) disable iff (reset_i)
    pid_a_o[SMP_W-1] == $past(prod[0][2*SMP_W]));
  a_sign_b: assert property (@(posedge adc_clk) disable iff (reset_i)
    pid_b_o[SMP_W-1] == $past(prod[1][2*SMP_W]));

endmodule

//--- design/asg_table.sv
`timescale 1ns/1ns

module asg_table (
  input  logic                  adc_clk,
  input  logic                  reset_i,
  input  logic                  wen_i,
  input  logic                  ren_i,
  input  rp_bus_pkg::offs_t     offs_i,
  input  rp_bus_pkg::sys_data_t wdata_i,
  output rp_bus_pkg::sys_data_t rdata_o,
  output logic                  ack_o,
  output rp_sig_pkg::smp_t      asg_a_o,
  output rp_sig_pkg::smp_t      asg_b_o
);
  import rp_bus_pkg::*;
  import rp_sig_pkg::*;

  smp_t            tbl [N_CH][TBL_DEPTH];  // waveform tables
  tbl_idx_t        ptr [N_CH];             // playback pointers
  smp_t            dat [N_CH];             // registered outputs
  logic [N_CH-1:0] ena;                    // bit 0 ch a, bit 1 ch b
  logic            tbl_hit;
  logic            ctl_hit;
  logic            tbl_ch;
  tbl_idx_t        tbl_ent;

  ////////////////////
  // address decode
  assign tbl_hit = (offs_i & ~offs_t'('h7f)) == OFS_ASG_TBL;  // 0x80..0xff
  assign ctl_hit = offs_i == OFS_ASG_CTL;
  assign tbl_ch  = offs_i[6];
  assign tbl_ent = offs_i[5:2];

  // control register and ack
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      ena   <= '0;
      ack_o <= 1'b0;
    end
    else
    begin
      ack_o <= wen_i | ren_i;
      if (wen_i && ctl_hit)
        ena <= wdata_i[N_CH-1:0];
    end
  end

  // table write and readback
  always_ff @(posedge adc_clk)
  begin
    if (wen_i && tbl_hit)
      tbl[tbl_ch][tbl_ent] <= smp_t'(wdata_i[SMP_W-1:0]);
    if (ren_i)
    begin
      if (tbl_hit)
        rdata_o <= {{(SYS_DW-SMP_W){1'b0}}, tbl[tbl_ch][tbl_ent]};
      else if (ctl_hit)
        rdata_o <= sys_data_t'(ena);
      else
        rdata_o <= '0;
    end
  end

  ////////////////////
  // playback, entry 0 shows the cycle after the enable ack
  always_ff @(posedge adc_clk)
  begin
    for (int ch = 0; ch < N_CH; ch++)
    begin
      if (reset_i || !ena[ch])
      begin
        ptr[ch] <= '0;  // disabled channel restarts at 0
        dat[ch] <= '0;
      end
      else
      begin
        dat[ch] <= tbl[ch][ptr[ch]];
        ptr[ch] <= ptr[ch] + 1'b1;  // wraps at 16
      end
    end
  end

  assign asg_a_o = dat[0];
  assign asg_b_o = dat[1];

endmodule

//--- design/hk_regs.sv
`timescale 1ns/1ns

module hk_regs (
  input  logic                  adc_clk,
  input  logic                  reset_i,
  input  logic                  wen_i,
  input  logic                  ren_i,
  input  rp_bus_pkg::offs_t     offs_i,
  input  rp_bus_pkg::sys_data_t wdata_i,
  output rp_bus_pkg::sys_data_t rdata_o,
  output logic                  ack_o,
  output logic                  loop_o,  // digital loopback
  output logic [7:0]            led_o
);
  import rp_bus_pkg::*;

  ////////////////////
  // control registers
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      loop_o <= 1'b0;
      led_o  <= '0;
      ack_o  <= 1'b0;
    end
    else
    begin
      ack_o <= wen_i | ren_i;  // every access answered next cycle
      if (wen_i)
      begin
        case (offs_i)
          OFS_LOOP: loop_o <= wdata_i[0];
          OFS_LED:  led_o  <= wdata_i[7:0];
          default:  ;  // unknown offset, write dropped
        endcase
      end
    end
  end

  // read data
  always_ff @(posedge adc_clk)
  begin
    if (ren_i)
    begin
      case (offs_i)
        OFS_LOOP: rdata_o <= sys_data_t'(loop_o);
        OFS_LED:  rdata_o <= sys_data_t'(led_o);
        default:  rdata_o <= '0;
      endcase
    end
  end

  // led byte moves only on a write to its own offset
  a_led_write_only: assert property (@(posedge adc_clk) disable iff (reset_i)
    $changed(led_o) |-> $past(wen_i && offs_i == OFS_LED));

endmodule

//--- design/adc_frontend.sv
`timescale 1ns/1ns

module adc_frontend (
  input  logic                 adc_clk,
  input  logic                 reset_i,
  input  rp_sig_pkg::adc_raw_t adc_dat_i,   // raw word, negative slope
  input  logic                 loop_i,      // digital loopback on
  input  rp_sig_pkg::smp_t     loop_dat_i,  // saturated DAC sum
  output rp_sig_pkg::smp_t     smp_o
);
  import rp_sig_pkg::*;

  logic [SMP_W-1:0] raw_q;  // top 14 bits of the ADC word
  smp_t             conv;

  // input register, low 2 bits dropped
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      raw_q <= {1'b0, {(SMP_W-1){1'b1}}};  // midscale code, converts to 0
    else
      raw_q <= adc_dat_i[ADC_RAW_W-1 -: SMP_W];
  end

  // negative slope to two's complement, msb kept
  assign conv = {raw_q[SMP_W-1], ~raw_q[SMP_W-2:0]};

  // loopback bypasses the ADC with no extra cycle
  assign smp_o = loop_i ? loop_dat_i : conv;

endmodule

//--- design/sys_bus_decoder.sv
`timescale 1ns/1ns

module sys_bus_decoder (
  input  logic                  adc_clk,
  input  logic                  reset_i,
  input  rp_bus_pkg::sys_addr_t sys_addr_i,
  input  rp_bus_pkg::sys_data_t sys_wdata_i,
  input  logic                  sys_wen_i,
  input  logic                  sys_ren_i,
  input  rp_bus_pkg::sys_data_t hk_rdata_i,
  input  rp_bus_pkg::sys_data_t asg_rdata_i,
  input  rp_bus_pkg::sys_data_t pid_rdata_i,
  input  logic                  hk_ack_i,
  input  logic                  asg_ack_i,
  input  logic                  pid_ack_i,
  output logic                  hk_wen_o,
  output logic                  hk_ren_o,
  output logic                  asg_wen_o,
  output logic                  asg_ren_o,
  output logic                  pid_wen_o,
  output logic                  pid_ren_o,
  output rp_bus_pkg::offs_t     offs_o,
  output rp_bus_pkg::sys_data_t wdata_o,
  output rp_bus_pkg::sys_data_t sys_rdata_o,
  output logic                  sys_err_o,
  output logic                  sys_ack_o
);
  import rp_bus_pkg::*;

  region_t region;    // region of the current request
  region_t region_q;  // region held for the read return
  logic    req;
  logic    mapped;
  logic    err_q;     // unmapped access, answered here

  assign region = sys_addr_i[REGION_LSB +: $bits(region_t)];
  assign req    = sys_wen_i | sys_ren_i;
  assign mapped = region inside {REG_HK, REG_ASG, REG_PID};

  ////////////////////
  // strobes to slaves, no register
  assign hk_wen_o  = sys_wen_i & (region == REG_HK);
  assign hk_ren_o  = sys_ren_i & (region == REG_HK);
  assign asg_wen_o = sys_wen_i & (region == REG_ASG);
  assign asg_ren_o = sys_ren_i & (region == REG_ASG);
  assign pid_wen_o = sys_wen_i & (region == REG_PID);
  assign pid_ren_o = sys_ren_i & (region == REG_PID);
  assign offs_o    = sys_addr_i[REGION_LSB-1:0];  // shared offset
  assign wdata_o   = sys_wdata_i;

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      region_q <= '0;
      err_q    <= 1'b0;
    end
    else
    begin
      err_q <= req & ~mapped;  // one cycle, like a slave
      if (req)
        region_q <= region;
    end
  end

  ////////////////////
  // return path
  always_comb
  begin
    case (region_q)
      REG_HK:  sys_rdata_o = hk_rdata_i;
      REG_ASG: sys_rdata_o = asg_rdata_i;
      REG_PID: sys_rdata_o = pid_rdata_i;
      default: sys_rdata_o = '0;  // unmapped reads as zero
    endcase
  end

  assign sys_err_o = err_q;
  assign sys_ack_o = hk_ack_i | asg_ack_i | pid_ack_i | err_q;

  // master never writes and reads in one cycle
  a_wen_ren_excl: assert property (@(posedge adc_clk) disable iff (reset_i)
    !(sys_wen_i && sys_ren_i));

endmodule

//--- design/rp_sig_pkg.sv
package rp_sig_pkg;

  localparam int N_CH = 2;  // two analog channels

  // raw ADC word, top 14 bits carry the sample
  localparam int ADC_RAW_W = 16;
  typedef logic [ADC_RAW_W-1:0] adc_raw_t;

  ////////////////////
  // sample format
  localparam int SMP_W = 14;
  typedef logic signed [SMP_W-1:0] smp_t;

  localparam smp_t SMP_MAX = {1'b0, {(SMP_W-1){1'b1}}};  // +8191
  localparam smp_t SMP_MIN = {1'b1, {(SMP_W-1){1'b0}}};  // -8192

  // generator table
  localparam int TBL_DEPTH = 16;
  typedef logic [$clog2(TBL_DEPTH)-1:0] tbl_idx_t;

  // controller gain, fixed point with PID_SHIFT fraction bits
  typedef logic signed [SMP_W-1:0] kp_t;
  localparam int PID_SHIFT = 8;

endpackage

//--- design/rp_bus_pkg.sv
package rp_bus_pkg;

  // system bus widths
  localparam int SYS_AW = 32;
  localparam int SYS_DW = 32;

  typedef logic [SYS_AW-1:0] sys_addr_t;
  typedef logic [SYS_DW-1:0] sys_data_t;

  ////////////////////
  // region map, addr[22:20] picks one of 8 regions
  localparam int N_REGIONS  = 8;
  localparam int REGION_LSB = 20;

  typedef logic [$clog2(N_REGIONS)-1:0] region_t;
  typedef logic [REGION_LSB-1:0]        offs_t;  // offset inside a region

  localparam region_t REG_HK  = 3'd0;  // housekeeping
  localparam region_t REG_ASG = 3'd1;  // generator
  localparam region_t REG_PID = 3'd2;  // controller, 3..7 unmapped

  ////////////////////
  // register offsets
  localparam offs_t OFS_LOOP    = 20'h0;
  localparam offs_t OFS_LED     = 20'h4;
  localparam offs_t OFS_ASG_CTL = 20'h0;
  localparam offs_t OFS_ASG_TBL = 20'h80;  // bit 6 channel, bits 5:2 entry
  localparam offs_t OFS_SP      = 20'h0;   // bit 4 picks the channel
  localparam offs_t OFS_KP      = 20'h4;

endpackage
